// ==== build.f ====
src/i2c_pkg.sv
src/i2c_master.sv
src/i2c_arbiter.sv
src/sensor_poller.sv
src/i2c_subsystem.sv
tests/tb_clock.sv
tests/i2c_slave_model.sv
tests/i2c_subsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" \
	&& verilator --binary -f build.f --top-module i2c_subsystem_tb -o sim_top \
	&& ./obj_dir/sim_top > sim.log 2>&1 \
	&& grep -q "^Test passed$" sim.log \
	&& echo "Simulation OK" \
	|| { echo "Simulation FAILED, see sim.log"; exit 1; }

// ==== tests/i2c_subsystem_tb.sv ====
`timescale 1ns/1ps

module i2c_subsystem_tb;

	localparam int wait_limit = 20000;
	localparam logic [6:0] slave_address = 7'h48;
	localparam logic [6:0] absent_address = 7'h21;

	logic clk;
	logic reset_n;
	logic [i2c_pkg::div_bits-1:0] clk_div;
	logic host_start;
	i2c_pkg::i2c_req_t host_req;
	logic host_busy;
	logic host_done;
	i2c_pkg::i2c_res_t host_res;
	logic poll_enable;
	logic [6:0] poll_address;
	logic [15:0] poll_period;
	logic [i2c_pkg::data_bits-1:0] poll_data;
	logic poll_valid;
	logic poll_error;
	logic scl;
	logic sda_out;
	logic sda_oe;
	logic sda_in;
	logic [15:0] model_reg;

	int error_count = 0;
	int timeout_count = 0;
	int host_requests = 0;
	int host_dones = 0;
	logic [31:0] lfsr_state = 32'ha03a;
	logic [15:0] written;	// Last value written to the target

	tb_clock #(.period(4.0), .reset_cycles(3)) tb_clock_i (.clk(clk), .reset_n(reset_n));

	i2c_subsystem i2c_subsystem_i (
		.clk(clk),
		.reset_n(reset_n),
		.clk_div(clk_div),
		.host_start(host_start),
		.host_req(host_req),
		.host_busy(host_busy),
		.host_done(host_done),
		.host_res(host_res),
		.poll_enable(poll_enable),
		.poll_address(poll_address),
		.poll_period(poll_period),
		.poll_data(poll_data),
		.poll_valid(poll_valid),
		.poll_error(poll_error),
		.scl(scl),
		.sda_out(sda_out),
		.sda_oe(sda_oe),
		.sda_in(sda_in)
	);

	i2c_slave_model #(.target_address(slave_address)) i2c_slave_model_i (
		.clk(clk),
		.scl(scl),
		.sda_out(sda_out),
		.sda_oe(sda_oe),
		.sda(sda_in),
		.reg_value(model_reg)
	);

	always @(negedge clk) begin
		if (host_done)
			host_dones <= host_dones + 1;
	end

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] galois_step(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	task automatic random_word(output logic [15:0] value);
		value = '0;
		for (int i = 0; i < 16; i++) begin
			value = {value[14:0], lfsr_state[0]};
			lfsr_state = galois_step(lfsr_state);
		end
	endtask

	function automatic i2c_pkg::i2c_res_t make_res(input logic [15:0] rdata, input logic err);
		i2c_pkg::i2c_res_t r;
		r.rdata = rdata;
		r.error = err;
		return r;
	endfunction

	task automatic check_res(input string test_name, input i2c_pkg::i2c_res_t expected,
		input i2c_pkg::i2c_res_t actual);
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %s: expected rdata %h error %b, actual rdata %h error %b",
				test_name, expected.rdata, expected.error, actual.rdata, actual.error);
		end
	endtask

	task automatic check_data(input string test_name,
		input logic [i2c_pkg::data_bits-1:0] expected, input logic [i2c_pkg::data_bits-1:0] actual);
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
		end
	endtask

	task automatic check_flag(input string test_name, input logic expected, input logic actual);
		if (actual !== expected) begin
			error_count++;
			$display("[ERROR] %s: expected %b, actual %b", test_name, expected, actual);
		end
	endtask

	task automatic check_count(input string test_name, input int expected, input int actual);
		if (actual != expected) begin
			error_count++;
			$display("[ERROR] %s: expected %0d, actual %0d", test_name, expected, actual);
		end
	endtask

	task automatic wait_host_done(input string test_name, output i2c_pkg::i2c_res_t res);
		int cycles;
		cycles = 0;
		while (!host_done && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		res = host_done ? host_res : '0;
		if (!host_done) begin
			timeout_count++;
			$display("Timeout in %s: host_done never arrived", test_name);
		end
	endtask

	// Level wait on poll_error or poll_valid
	task automatic wait_poll(input string test_name, input logic want_error);
		int cycles;
		cycles = 0;
		while (!(want_error ? poll_error : poll_valid) && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (!(want_error ? poll_error : poll_valid)) begin
			timeout_count++;
			$display("Timeout in %s: %s never went high", test_name,
				want_error ? "poll_error" : "poll_valid");
		end
	endtask

	task automatic host_transfer(input string test_name, input logic [6:0] address,
		input logic write_n, input logic bits16, input logic [15:0] wdata,
		input logic extra_strobe, output i2c_pkg::i2c_res_t res);
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (host_busy && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		if (host_busy) begin
			timeout_count++;
			$display("Timeout in %s: host_busy never went low", test_name);
		end
		host_req = '{address: address, write_n: write_n, bits16: bits16, wdata: wdata};
		host_start = 1'b1;
		host_requests++;
		@(negedge clk);
		host_start = extra_strobe;	// Second strobe lands while busy
		if (extra_strobe) begin
			@(negedge clk);
			host_start = 1'b0;
		end
		wait_host_done(test_name, res);
	endtask

	task automatic test_reset();
		int cycles;
		cycles = 0;
		while (!reset_n && cycles < 100) begin
			@(posedge clk);
			cycles++;
		end
		if (!reset_n) begin
			timeout_count++;
			$display("Timeout in reset: reset_n never went high");
		end
		repeat (6) begin
			@(negedge clk);
			check_flag("reset_scl", 1'b1, scl);
			check_flag("reset_sda_out", 1'b1, sda_out);
			check_flag("reset_sda_oe", 1'b1, sda_oe);
			check_flag("reset_host_busy", 1'b0, host_busy);
			check_flag("reset_host_done", 1'b0, host_done);
			check_flag("reset_poll_valid", 1'b0, poll_valid);
		end
	endtask

	task automatic test_write_read();
		i2c_pkg::i2c_res_t res;
		logic [15:0] value;
		random_word(value);
		host_transfer("write16", slave_address, 1'b0, 1'b1, value, 1'b0, res);
		check_flag("write16", 1'b0, res.error);
		written = value;
		host_transfer("read16", slave_address, 1'b1, 1'b1, '0, 1'b0, res);
		check_res("read16", make_res(written, 1'b0), res);
		host_transfer("read8", slave_address, 1'b1, 1'b0, '0, 1'b0, res);
		check_res("read8", make_res({8'h00, written[15:8]}, 1'b0), res);	// Upper byte
	endtask

	task automatic test_nack();
		i2c_pkg::i2c_res_t res;
		host_transfer("nack_read", absent_address, 1'b1, 1'b1, '0, 1'b0, res);
		check_res("nack_read", make_res('0, 1'b1), res);
		host_transfer("nack_write", absent_address, 1'b0, 1'b1, 16'h5a5a, 1'b0, res);
		check_res("nack_write", make_res('0, 1'b1), res);
		host_transfer("after_nack", slave_address, 1'b1, 1'b1, '0, 1'b0, res);
		check_res("after_nack", make_res(written, 1'b0), res);
	endtask

	task automatic test_poller();
		@(negedge clk);
		poll_address = slave_address;
		poll_period = 16'd2000;
		poll_enable = 1'b1;
		wait_poll("poll_read", 1'b0);
		check_data("poll_read", written, poll_data);
		check_data("poll_model", written, model_reg);
		poll_address = absent_address;
		wait_poll("poll_nack", 1'b1);
		check_data("poll_nack_keep", written, poll_data);
	endtask

	task automatic test_contention();
		i2c_pkg::i2c_res_t res;
		i2c_pkg::owner_t who;
		logic [15:0] value;
		int first_done;
		@(negedge clk);
		poll_enable = 1'b0;	// Timer reloads with the short period
		poll_address = slave_address;
		poll_period = 16'd150;	// Poller keeps the master busy
		@(negedge clk);
		poll_enable = 1'b1;
		first_done = host_dones;
		for (int n = 0; n < 4; n++) begin
			random_word(value);
			host_transfer("busy_write", slave_address, 1'b0, 1'b1, value, 1'b0, res);
			check_flag("busy_write", 1'b0, res.error);
			written = value;
			host_transfer("busy_read", slave_address, 1'b1, 1'b1, '0, 1'b1, res);
			check_res("busy_read", make_res(written, 1'b0), res);
		end
		repeat (20) @(negedge clk);
		check_count("done_per_request", host_requests, host_dones);
		check_flag("busy_poll_error", 1'b0, poll_error);
		who = i2c_pkg::owner_host;
		$display("Contention: %0d transfers done for %s", host_dones - first_done, who.name());
	endtask

	initial begin
		clk_div = 8'd8;
		host_start = 1'b0;
		host_req = '0;
		poll_enable = 1'b0;
		poll_address = '0;
		poll_period = 16'd2000;
		written = '0;
		test_reset();
		test_write_read();
		test_nack();
		test_poller();
		test_contention();
		$display("Closing: %0d value errors, %0d timeouts", error_count, timeout_count);
		if (error_count == 0 && timeout_count == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== tests/i2c_slave_model.sv ====
`timescale 1ns/1ps

module i2c_slave_model #(
	parameter logic [6:0] target_address = 7'h48
) (
	input logic clk,
	input logic scl,
	input logic sda_out,
	input logic sda_oe,
	output logic sda,
	output logic [15:0] reg_value
);

	typedef enum logic [1:0] {
		wait_start,
		get_addr,
		give_ack,
		move_data
	} phase_t;

	phase_t phase = wait_start;
	logic scl_q = 1'b1;
	logic sda_q = 1'b1;
	logic [7:0] addr_sr = '0;
	logic [4:0] bit_cnt = '0;
	logic reading = 1'b0;
	logic ack_pull = 1'b0;
	logic read_out = 1'b0;
	logic out_bit = 1'b1;
	logic [15:0] out_sr = '0;
	logic held_bit = 1'b0;
	logic have_bit = 1'b0;	// Sampled bit, kept until SCL falls again
	logic [15:0] data_reg = '0;

	logic scl_rise;
	logic scl_fall;
	logic start_cond;
	logic stop_cond;

	// Open drain bus, low wins
	assign sda = (sda_oe ? sda_out : 1'b1) & !ack_pull & !(read_out && !sda_oe && !out_bit);
	assign reg_value = data_reg;

	assign scl_rise = !scl_q && scl;
	assign scl_fall = scl_q && !scl;
	assign start_cond = scl_q && scl && sda_q && !sda;
	assign stop_cond = scl_q && scl && !sda_q && sda;

	always @(negedge clk) begin
		scl_q <= scl;
		sda_q <= sda;
		if (start_cond) begin
			phase <= get_addr;
			bit_cnt <= '0;
			ack_pull <= 1'b0;
			read_out <= 1'b0;
			have_bit <= 1'b0;
		end else if (stop_cond) begin
			phase <= wait_start;
			read_out <= 1'b0;
			have_bit <= 1'b0;	// Stop clock is not data
		end else if (scl_rise) begin
			if (phase == get_addr) begin
				addr_sr <= {addr_sr[6:0], sda};
				bit_cnt <= bit_cnt + 1'b1;
			end else if (phase == move_data && !reading) begin
				held_bit <= sda;
				have_bit <= 1'b1;
			end
		end else if (scl_fall) begin
			case (phase)
				get_addr: begin
					if (bit_cnt == 5'd8) begin
						if (addr_sr[7:1] == target_address) begin
							ack_pull <= 1'b1;
							reading <= addr_sr[0];
							phase <= give_ack;
						end else begin
							phase <= wait_start;
						end
					end
				end
				give_ack: begin
					ack_pull <= 1'b0;
					phase <= move_data;
					read_out <= reading;
					out_bit <= data_reg[15];	// MSB first
					out_sr <= data_reg << 1;
					bit_cnt <= 5'd1;
				end
				move_data: begin
					if (have_bit) begin
						data_reg <= {data_reg[14:0], held_bit};
						have_bit <= 1'b0;
					end
					if (reading && bit_cnt < 5'd16) begin
						out_bit <= out_sr[15];
						out_sr <= out_sr << 1;
						bit_cnt <= bit_cnt + 1'b1;
					end else if (reading) begin
						read_out <= 1'b0;
					end
				end
				default: ;
			endcase
		end
	end

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
	parameter real period = 4.0,
	parameter int reset_cycles = 3
) (
	output logic clk,
	output logic reset_n
);

	initial begin
		clk = 1'b0;
		forever #(period / 2.0) clk = ~clk;
	end

	// Reset released on a falling edge
	initial begin
		reset_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		reset_n = 1'b1;
	end

endmodule

// ==== src/i2c_subsystem.sv ====
`timescale 1ns/1ps

module i2c_subsystem (
	input logic clk,
	input logic reset_n,
	input logic [i2c_pkg::div_bits-1:0] clk_div,
	input logic host_start,
	input i2c_pkg::i2c_req_t host_req,
	output logic host_busy,
	output logic host_done,
	output i2c_pkg::i2c_res_t host_res,
	input logic poll_enable,
	input logic [6:0] poll_address,
	input logic [15:0] poll_period,
	output logic [i2c_pkg::data_bits-1:0] poll_data,
	output logic poll_valid,
	output logic poll_error,
	output logic scl,
	output logic sda_out,
	output logic sda_oe,
	input logic sda_in
);

	logic poll_start;
	logic poll_done;
	i2c_pkg::i2c_req_t poll_req;
	i2c_pkg::i2c_res_t poll_res;

	logic m_start;
	logic m_busy;
	logic m_done;
	i2c_pkg::i2c_req_t m_req;
	i2c_pkg::i2c_res_t m_res;

	sensor_poller sensor_poller_i (
		.clk(clk),
		.reset_n(reset_n),
		.poll_enable(poll_enable),
		.poll_address(poll_address),
		.poll_period(poll_period),
		.poll_start(poll_start),
		.poll_req(poll_req),
		.poll_done(poll_done),
		.poll_res(poll_res),
		.poll_data(poll_data),
		.poll_valid(poll_valid),
		.poll_error(poll_error)
	);

	i2c_arbiter i2c_arbiter_i (
		.clk(clk),
		.reset_n(reset_n),
		.host_start(host_start),
		.host_req(host_req),
		.poll_start(poll_start),
		.poll_req(poll_req),
		.host_busy(host_busy),
		.host_done(host_done),
		.host_res(host_res),
		.poll_done(poll_done),
		.poll_res(poll_res),
		.m_start(m_start),
		.m_req(m_req),
		.m_busy(m_busy),
		.m_done(m_done),
		.m_res(m_res)
	);

	i2c_master i2c_master_i (
		.clk(clk),
		.reset_n(reset_n),
		.start(m_start),
		.req(m_req),
		.clk_div(clk_div),
		.busy(m_busy),
		.done(m_done),
		.res(m_res),
		.scl(scl),
		.sda_out(sda_out),
		.sda_oe(sda_oe),
		.sda_in(sda_in)
	);

endmodule

// ==== src/sensor_poller.sv ====
`timescale 1ns/1ps

module sensor_poller (
	input logic clk,
	input logic reset_n,
	input logic poll_enable,
	input logic [6:0] poll_address,
	input logic [15:0] poll_period,
	output logic poll_start,
	output i2c_pkg::i2c_req_t poll_req,
	input logic poll_done,
	input i2c_pkg::i2c_res_t poll_res,
	output logic [i2c_pkg::data_bits-1:0] poll_data,
	output logic poll_valid,
	output logic poll_error
);

	logic [15:0] timer;
	logic waiting;	// Read issued, result not back yet
	logic expire;

	assign expire = (timer == '0);

	// Always a 16-bit register read
	always_comb begin
		poll_req.address = poll_address;
		poll_req.write_n = 1'b1;
		poll_req.bits16 = 1'b1;
		poll_req.wdata = '0;
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			timer <= '0;
			waiting <= 1'b0;
			poll_start <= 1'b0;
			poll_valid <= 1'b0;
			poll_error <= 1'b0;
		end else begin
			poll_start <= 1'b0;

			if (!poll_enable) begin
				timer <= poll_period;	// First poll a full period after enable
			end else if (expire) begin
				timer <= poll_period;
				if (!waiting) begin
					poll_start <= 1'b1;
					waiting <= 1'b1;
				end
			end else begin
				timer <= timer - 1'b1;
			end

			if (poll_done) begin
				waiting <= 1'b0;
				if (poll_res.error) begin
					poll_error <= 1'b1;
				end else begin
					poll_valid <= 1'b1;
					poll_error <= 1'b0;
				end
			end
		end
	end

	// Last good value, kept across a NACK
	always_ff @(posedge clk) begin
		if (poll_done && !poll_res.error)
			poll_data <= poll_res.rdata;
	end

endmodule

// ==== src/i2c_arbiter.sv ====
`timescale 1ns/1ps

module i2c_arbiter (
	input logic clk,
	input logic reset_n,
	input logic host_start,
	input i2c_pkg::i2c_req_t host_req,
	input logic poll_start,
	input i2c_pkg::i2c_req_t poll_req,
	output logic host_busy,
	output logic host_done,
	output i2c_pkg::i2c_res_t host_res,
	output logic poll_done,
	output i2c_pkg::i2c_res_t poll_res,
	output logic m_start,
	output i2c_pkg::i2c_req_t m_req,
	input logic m_busy,
	input logic m_done,
	input i2c_pkg::i2c_res_t m_res
);

	logic host_pend;
	logic poll_pend;
	logic granted;	// Transfer handed out, waiting for m_done
	i2c_pkg::i2c_req_t host_req_q;
	i2c_pkg::i2c_req_t poll_req_q;
	i2c_pkg::i2c_req_t host_sel;
	i2c_pkg::i2c_req_t poll_sel;
	i2c_pkg::i2c_res_t host_res_q;
	i2c_pkg::owner_t last_owner;
	i2c_pkg::owner_t pick;

	logic host_accept;
	logic host_want;
	logic poll_want;
	logic grant;

	assign host_accept = host_start && !host_busy;	// Strobe while busy is dropped
	assign host_want = host_pend || host_accept;
	assign poll_want = poll_pend || poll_start;
	assign grant = !m_busy && !granted && (host_want || poll_want);

	assign host_sel = host_pend ? host_req_q : host_req;
	assign poll_sel = poll_pend ? poll_req_q : poll_req;

	// Round robin when both wait
	always_comb begin
		if (host_want && poll_want)
			pick = (last_owner == i2c_pkg::owner_host) ? i2c_pkg::owner_poller : i2c_pkg::owner_host;
		else if (host_want)
			pick = i2c_pkg::owner_host;
		else
			pick = i2c_pkg::owner_poller;
	end

	assign host_done = m_done && (last_owner == i2c_pkg::owner_host);
	assign poll_done = m_done && (last_owner == i2c_pkg::owner_poller);
	assign host_res = host_done ? m_res : host_res_q;
	assign poll_res = m_res;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			host_pend <= 1'b0;
			poll_pend <= 1'b0;
			granted <= 1'b0;
			m_start <= 1'b0;
			host_busy <= 1'b0;
			last_owner <= i2c_pkg::owner_poller;	// Host wins the first tie
		end else begin
			m_start <= grant;
			if (host_accept)
				host_busy <= 1'b1;
			else if (host_done)
				host_busy <= 1'b0;
			if (grant) begin
				granted <= 1'b1;
				last_owner <= pick;
			end else if (m_done) begin
				granted <= 1'b0;
			end
			host_pend <= host_want && !(grant && pick == i2c_pkg::owner_host);
			poll_pend <= poll_want && !(grant && pick == i2c_pkg::owner_poller);
		end
	end

	always_ff @(posedge clk) begin
		if (host_accept)
			host_req_q <= host_req;
		if (poll_start)
			poll_req_q <= poll_req;
		if (grant)
			m_req <= (pick == i2c_pkg::owner_host) ? host_sel : poll_sel;
		if (host_done)
			host_res_q <= m_res;
	end

endmodule

// ==== src/i2c_master.sv ====
`timescale 1ns/1ps

module i2c_master (
	input logic clk,
	input logic reset_n,
	input logic start,
	input i2c_pkg::i2c_req_t req,
	input logic [i2c_pkg::div_bits-1:0] clk_div,
	output logic busy,
	output logic done,
	output i2c_pkg::i2c_res_t res,
	output logic scl,
	output logic sda_out,
	output logic sda_oe,
	input logic sda_in
);

	i2c_pkg::master_state_t state;

	logic read_q;
	logic bits16_q;
	logic [i2c_pkg::div_bits-1:0] div_q;
	logic [i2c_pkg::div_bits-1:0] cnt;
	logic [i2c_pkg::div_bits-1:0] half_cnt;
	logic [i2c_pkg::div_bits-1:0] mid_cnt;
	logic [7:0] addr_sr;
	logic [2:0] addr_left;
	logic [i2c_pkg::data_bits-1:0] data_sr;
	logic [i2c_pkg::count_bits-1:0] data_left;

	logic load;
	logic at_zero;
	logic at_half;
	logic at_mid;

	assign half_cnt = div_q >> 1;	// SCL rises
	assign mid_cnt = half_cnt + (half_cnt >> 1);	// Middle of SCL low

	assign load = (state == i2c_pkg::idle) && start;
	assign at_zero = (cnt == '0);	// SCL falls
	assign at_half = (cnt == half_cnt);
	assign at_mid = (cnt == mid_cnt);

	// Address and data shifters, loaded at start
	always_ff @(posedge clk) begin
		if (load) begin
			read_q <= req.write_n;
			bits16_q <= req.bits16;
			div_q <= clk_div;
			addr_sr <= {req.address, req.write_n};
			if (req.write_n)
				data_sr <= '0;
			else if (req.bits16)
				data_sr <= req.wdata;
			else
				data_sr <= {req.wdata[i2c_pkg::data_bits/2-1:0],
					{(i2c_pkg::data_bits/2){1'b0}}};	// Byte sent from the top
		end else begin
			if (at_mid && (state == i2c_pkg::wait_first || state == i2c_pkg::addr_phase))
				addr_sr <= addr_sr << 1;
			if (state == i2c_pkg::data_phase) begin
				if (at_mid && !read_q)
					data_sr <= data_sr << 1;
				if (at_half && read_q)
					data_sr <= {data_sr[i2c_pkg::data_bits-2:0], sda_in};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= i2c_pkg::idle;
			busy <= 1'b0;
			done <= 1'b0;
			res <= '0;
			scl <= 1'b1;
			sda_out <= 1'b1;
			sda_oe <= 1'b1;
			cnt <= '0;
			addr_left <= '0;
			data_left <= '0;
		end else begin
			done <= 1'b0;
			cnt <= at_zero ? div_q - 1'b1 : cnt - 1'b1;

			case (state)
				i2c_pkg::idle: begin
					scl <= 1'b1;
					sda_out <= 1'b1;
					sda_oe <= 1'b1;
					if (start) begin
						busy <= 1'b1;
						cnt <= clk_div - 1'b1;
						state <= i2c_pkg::start_seq;
					end
				end

				i2c_pkg::start_seq: begin
					if (at_half)
						sda_out <= 1'b0;	// Start condition, SDA falls with SCL high
					if (at_zero) begin
						scl <= 1'b0;
						state <= i2c_pkg::wait_first;
					end
				end

				i2c_pkg::wait_first: begin
					if (at_mid) begin
						sda_out <= addr_sr[7];
						addr_left <= 3'd7;
					end
					if (at_half) begin
						scl <= 1'b1;
						state <= i2c_pkg::addr_phase;
					end
				end

				i2c_pkg::addr_phase: begin
					if (at_zero) begin
						scl <= 1'b0;
						if (addr_left == '0)
							state <= i2c_pkg::ack_phase;
					end
					if (at_mid) begin
						sda_out <= addr_sr[7];
						addr_left <= addr_left - 1'b1;
					end
					if (at_half)
						scl <= 1'b1;
				end

				i2c_pkg::ack_phase: begin
					if (at_mid)
						sda_oe <= 1'b0;	// Target drives ACK
					if (at_half) begin
						scl <= 1'b1;
						if (sda_in) begin
							// NACK ends without stop
							busy <= 1'b0;
							done <= 1'b1;
							res <= '{rdata: '0, error: 1'b1};
							state <= i2c_pkg::idle;
						end else begin
							data_left <= bits16_q ? i2c_pkg::full_count : i2c_pkg::half_count;
							state <= i2c_pkg::data_phase;
						end
					end
				end

				i2c_pkg::data_phase: begin
					if (at_zero) begin
						scl <= 1'b0;
						if (data_left == '0)
							state <= i2c_pkg::wait_last;
					end
					if (at_mid && !read_q) begin
						sda_oe <= 1'b1;
						sda_out <= data_sr[i2c_pkg::data_bits-1];
					end
					if (at_half) begin
						scl <= 1'b1;
						data_left <= data_left - 1'b1;
					end
				end

				i2c_pkg::wait_last: begin
					if (at_mid) begin
						sda_oe <= 1'b1;
						sda_out <= 1'b0;	// Low ahead of stop
					end
					if (at_half) begin
						scl <= 1'b1;
						state <= i2c_pkg::stop;
					end
				end

				i2c_pkg::stop: begin
					if (at_zero) begin
						sda_out <= 1'b1;	// Stop condition
						busy <= 1'b0;
						done <= 1'b1;
						res <= '{rdata: data_sr, error: 1'b0};
						state <= i2c_pkg::idle;
					end
				end

				default: state <= i2c_pkg::idle;
			endcase
		end
	end

endmodule

// ==== src/i2c_pkg.sv ====
package i2c_pkg;

	localparam int data_bits = 16;
	localparam int div_bits = 8;

	// Data bit counter, holds 0 to data_bits
	localparam int count_bits = $clog2(data_bits) + 1;
	localparam logic [count_bits-1:0] full_count = count_bits'(data_bits);
	localparam logic [count_bits-1:0] half_count = count_bits'(data_bits / 2);

	typedef struct packed {
		logic [6:0] address;
		logic write_n;	// 0 for write
		logic bits16;	// 0 for 8-bit transfer
		logic [data_bits-1:0] wdata;
	} i2c_req_t;

	typedef struct packed {
		logic [data_bits-1:0] rdata;
		logic error;	// Address NACK
	} i2c_res_t;

	typedef enum logic [2:0] {
		idle,
		start_seq,
		wait_first,
		addr_phase,
		ack_phase,
		data_phase,
		wait_last,
		stop
	} master_state_t;

	typedef enum logic {
		owner_host,
		owner_poller
	} owner_t;

endpackage
